// File: hdl/even_decode.sv
`default_nettype none
`timescale 1ns/100ps

module even_decode (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic                                 issue,
    input  wire spu_isa_pkg::opcode_e                 opcode,
    input  wire spu_data_pkg::quadword_u              ra,
    input  wire spu_data_pkg::quadword_u              rb,
    input  wire logic [spu_data_pkg::IMM10_WIDTH-1:0] imm10,
    input  wire logic [spu_data_pkg::IMM7_WIDTH-1:0]  imm7,
    input  wire spu_data_pkg::reg_addr_t              rt_addr,
    output spu_isa_pkg::even_ctrl_t                   ctrl,
    output spu_data_pkg::quadword_u                   op_a,
    output spu_data_pkg::quadword_u                   op_b
);

    spu_isa_pkg::fx_op_e               op_sel;
    logic                              half;
    logic                              imm;
    logic                              sr_sel;
    logic                              kept;
    logic [spu_data_pkg::HALFWORD-1:0] imm_h;
    logic [spu_data_pkg::WORD-1:0]     imm_w;
    spu_isa_pkg::even_ctrl_t           dec;
    spu_data_pkg::quadword_u           operand_b;

    assign op_sel = spu_isa_pkg::fx_op_e'(opcode[5:2]);
    assign half   = opcode[1];
    assign imm    = opcode[0];
    assign sr_sel = opcode[5:3] == 3'b111;  // operations 14 and 15

    always_comb begin
        case (op_sel)
            spu_isa_pkg::CARRY, spu_isa_pkg::BORROW, spu_isa_pkg::ANDC,
            spu_isa_pkg::ORC, spu_isa_pkg::NAND, spu_isa_pkg::NOR:
                kept = !half && !imm;  // word register form only
            spu_isa_pkg::AND, spu_isa_pkg::OR, spu_isa_pkg::XOR:
                kept = !half || imm;   // register form is lane independent
            default:
                kept = 1'b1;
        endcase
    end

    always_comb begin
        dec          = '0;
        dec.valid    = issue && kept;
        dec.halfword = half;
        dec.rt_addr  = rt_addr;
        if (!kept) begin
            dec.unit_id = spu_isa_pkg::NO_UNIT;
        end else if (sr_sel) begin
            dec.unit_id = spu_isa_pkg::SIMPLE_FIXED_2;
        end else begin
            dec.unit_id = spu_isa_pkg::SIMPLE_FIXED_1;
        end
        if (sr_sel) begin
            dec.sr_op = spu_isa_pkg::sr_op_e'({1'b0, opcode[2]});
        end else begin
            dec.fx_op = op_sel;
        end
    end

    // immediate operand replicated into every lane
    always_comb begin
        if (sr_sel) begin
            imm_h = {10'd0, imm7[5:0]};  // shift count
            imm_w = {26'd0, imm7[5:0]};
        end else begin
            imm_h = {{6{imm10[9]}}, imm10};
            imm_w = {{22{imm10[9]}}, imm10};
        end
        operand_b = rb;
        if (imm && half) begin
            operand_b.half = {8{imm_h}};
        end else if (imm) begin
            operand_b.word = {4{imm_w}};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= '0;
        end else begin
            ctrl <= dec;
        end
    end

    always_ff @(posedge clk) begin
        op_a <= ra;
        op_b <= operand_b;
    end

    // an issued slot must carry a known opcode
    assert property (@(posedge clk) disable iff (!arst_n) issue |-> !$isunknown(opcode))
        else $error("even_decode: unknown opcode while issue is high");

endmodule

`default_nettype wire

// File: hdl/even_pipe.sv
`default_nettype none
`timescale 1ns/100ps

module even_pipe (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n,
    input  wire logic                                 issue,
    input  wire spu_isa_pkg::opcode_e                 opcode,
    input  wire spu_data_pkg::quadword_u              ra,
    input  wire spu_data_pkg::quadword_u              rb,
    input  wire logic [spu_data_pkg::IMM10_WIDTH-1:0] imm10,
    input  wire logic [spu_data_pkg::IMM7_WIDTH-1:0]  imm7,
    input  wire spu_data_pkg::reg_addr_t              rt_addr,
    output spu_data_pkg::writeback_t                  wb
);

    spu_isa_pkg::even_ctrl_t dec_ctrl;
    spu_isa_pkg::even_ctrl_t fx_ctrl;
    spu_isa_pkg::even_ctrl_t sr_ctrl;
    spu_data_pkg::quadword_u op_a;
    spu_data_pkg::quadword_u op_b;
    spu_data_pkg::quadword_u fx_result;
    spu_data_pkg::quadword_u sr_result;

    even_decode decode_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .opcode  (opcode),
        .ra      (ra),
        .rb      (rb),
        .imm10   (imm10),
        .imm7    (imm7),
        .rt_addr (rt_addr),
        .ctrl    (dec_ctrl),
        .op_a    (op_a),
        .op_b    (op_b)
    );

    even_simple_fixed simple_fixed_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl_in  (dec_ctrl),
        .op_a     (op_a),
        .op_b     (op_b),
        .ctrl_out (fx_ctrl),
        .result   (fx_result)
    );

    even_shift_rotate shift_rotate_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl_in  (dec_ctrl),
        .op_a     (op_a),
        .op_b     (op_b),
        .ctrl_out (sr_ctrl),
        .result   (sr_result)
    );

    even_result result_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .fx_ctrl   (fx_ctrl),
        .sr_ctrl   (sr_ctrl),
        .fx_result (fx_result),
        .sr_result (sr_result),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// File: hdl/even_result.sv
`default_nettype none
`timescale 1ns/100ps

module even_result (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire spu_isa_pkg::even_ctrl_t fx_ctrl,
    input  wire spu_isa_pkg::even_ctrl_t sr_ctrl,
    input  wire spu_data_pkg::quadword_u fx_result,
    input  wire spu_data_pkg::quadword_u sr_result,
    output spu_data_pkg::writeback_t     wb
);

    spu_isa_pkg::even_ctrl_t  sel_ctrl;
    spu_data_pkg::writeback_t wb_next;

    always_comb begin
        sel_ctrl        = fx_ctrl;
        wb_next         = '0;
        wb_next.rt_data = fx_result;
        if (fx_ctrl.unit_id == spu_isa_pkg::SIMPLE_FIXED_2) begin
            sel_ctrl        = sr_ctrl;
            wb_next.rt_data = sr_result;
        end
        wb_next.reg_wr_en = sel_ctrl.valid;
        wb_next.unit_id   = sel_ctrl.unit_id;
        wb_next.rt_addr   = sel_ctrl.rt_addr;
        if (!sel_ctrl.valid)
            wb_next.rt_data = '0;  // idle slot
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb <= wb_next;
        end
    end

    // both execute units carry the same instruction each cycle
    assert property (@(posedge clk) disable iff (!arst_n) fx_ctrl == sr_ctrl)
        else $error("even_result: execute unit controls disagree");

endmodule

`default_nettype wire

// File: hdl/even_shift_rotate.sv
`default_nettype none
`timescale 1ns/100ps

module even_shift_rotate (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire spu_isa_pkg::even_ctrl_t ctrl_in,
    input  wire spu_data_pkg::quadword_u op_a,
    input  wire spu_data_pkg::quadword_u op_b,
    output spu_isa_pkg::even_ctrl_t      ctrl_out,
    output spu_data_pkg::quadword_u      result
);

    spu_data_pkg::quadword_u               res;
    logic [2*spu_data_pkg::HALFWORD-1:0]   rot_h;
    logic [2*spu_data_pkg::WORD-1:0]       rot_w;
    logic                                  rotate;

    assign rotate = ctrl_in.sr_op == spu_isa_pkg::ROT;

    // rotate takes the upper half of the lane doubled and shifted
    // shift counts at or above the lane width push every bit out
    always_comb begin
        res   = '0;
        rot_h = '0;
        rot_w = '0;
        if (ctrl_in.halfword) begin
            for (int i = 0; i < 8; i++) begin
                rot_h       = {op_a.half[i], op_a.half[i]} << op_b.half[i][3:0];
                res.half[i] = rotate ? rot_h[31:16]
                                     : op_a.half[i] << op_b.half[i][4:0];
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                rot_w       = {op_a.word[i], op_a.word[i]} << op_b.word[i][4:0];
                res.word[i] = rotate ? rot_w[63:32]
                                     : op_a.word[i] << op_b.word[i][5:0];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_out <= '0;
        end else begin
            ctrl_out <= ctrl_in;
        end
    end

    always_ff @(posedge clk) begin
        result <= res;
    end

endmodule

`default_nettype wire

// File: hdl/even_simple_fixed.sv
`default_nettype none
`timescale 1ns/100ps

module even_simple_fixed (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire spu_isa_pkg::even_ctrl_t ctrl_in,
    input  wire spu_data_pkg::quadword_u op_a,
    input  wire spu_data_pkg::quadword_u op_b,
    output spu_isa_pkg::even_ctrl_t      ctrl_out,
    output spu_data_pkg::quadword_u      result
);

    spu_data_pkg::quadword_u       res;
    logic [spu_data_pkg::WORD-1:0] lane;
    logic                          sign_ext;

    // one word lane, halfword lanes arrive already extended
    function automatic logic [spu_data_pkg::WORD-1:0] fx_lane(
        input spu_isa_pkg::fx_op_e           op,
        input logic [spu_data_pkg::WORD-1:0] a,
        input logic [spu_data_pkg::WORD-1:0] b
    );
        logic [spu_data_pkg::WORD:0]   sum;
        logic [spu_data_pkg::WORD-1:0] r;
        sum = {1'b0, a} + {1'b0, b};
        r   = '0;
        case (op)
            spu_isa_pkg::ADD:      r = sum[spu_data_pkg::WORD-1:0];
            spu_isa_pkg::SUB_FROM: r = b - a;
            spu_isa_pkg::CARRY:    r[0] = sum[spu_data_pkg::WORD];
            spu_isa_pkg::BORROW:   r[0] = b >= a;
            spu_isa_pkg::AND:      r = a & b;
            spu_isa_pkg::ANDC:     r = a & ~b;
            spu_isa_pkg::OR:       r = a | b;
            spu_isa_pkg::ORC:      r = a | ~b;
            spu_isa_pkg::XOR:      r = a ^ b;
            spu_isa_pkg::NAND:     r = ~(a & b);
            spu_isa_pkg::NOR:      r = ~(a | b);
            spu_isa_pkg::CEQ:      r[0] = a == b;
            spu_isa_pkg::CGT:      r[0] = $signed(a) > $signed(b);
            spu_isa_pkg::CLGT:     r[0] = a > b;
            default:               r = '0;
        endcase
        return r;
    endfunction

    assign sign_ext = ctrl_in.fx_op == spu_isa_pkg::CGT;  // only the signed compare

    always_comb begin
        res  = '0;
        lane = '0;
        if (ctrl_in.halfword) begin
            for (int i = 0; i < 8; i++) begin
                lane = fx_lane(ctrl_in.fx_op,
                               {{16{sign_ext & op_a.half[i][15]}}, op_a.half[i]},
                               {{16{sign_ext & op_b.half[i][15]}}, op_b.half[i]});
                res.half[i] = lane[15:0];
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                res.word[i] = fx_lane(ctrl_in.fx_op, op_a.word[i], op_b.word[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_out <= '0;
        end else begin
            ctrl_out <= ctrl_in;
        end
    end

    always_ff @(posedge clk) begin
        result <= res;
    end

    // decode never produces halfword carry or borrow
    assert property (@(posedge clk) disable iff (!arst_n)
        ctrl_in.valid && ctrl_in.halfword
            |-> !(ctrl_in.fx_op inside {spu_isa_pkg::CARRY, spu_isa_pkg::BORROW}))
        else $error("even_simple_fixed: halfword carry or borrow reached the unit");

endmodule

`default_nettype wire

// File: hdl/spu_data_pkg.sv
`default_nettype none

package spu_data_pkg;

    parameter int BYTE     = 8;
    parameter int HALFWORD = 2 * BYTE;
    parameter int WORD     = 4 * BYTE;
    parameter int QUADWORD = 16 * BYTE;

    parameter int REG_ADDR_WIDTH = 7;
    parameter int IMM10_WIDTH    = 10;
    parameter int IMM7_WIDTH     = 7;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // one register value, read as words or halfwords depending on the opcode
    // lane 0 sits in the most significant bits
    typedef union packed {
        logic [0:QUADWORD/WORD-1][WORD-1:0]         word;
        logic [0:QUADWORD/HALFWORD-1][HALFWORD-1:0] half;
    } quadword_u;

    typedef struct packed {
        logic       reg_wr_en;
        logic [1:0] unit_id;    // unit_id_e encoding
        reg_addr_t  rt_addr;
        quadword_u  rt_data;
    } writeback_t;

endpackage

`default_nettype wire

// File: hdl/spu_isa_pkg.sv
`default_nettype none

package spu_isa_pkg;

    parameter int INTERNAL_OPCODE_SIZE = 6;

    // opcode bits are {operation, halfword, immediate}
    // the operation field follows fx_op_e, with 14 and 15 for shift and rotate
    typedef enum logic [INTERNAL_OPCODE_SIZE-1:0] {
        ADD_WORD                      = 6'b0000_00,
        ADD_WORD_IMMEDIATE            = 6'b0000_01,
        ADD_HALFWORD                  = 6'b0000_10,
        ADD_HALFWORD_IMMEDIATE        = 6'b0000_11,
        SUBTRACT_FROM_WORD            = 6'b0001_00,
        SUBTRACT_FROM_WORD_IMMEDIATE  = 6'b0001_01,
        SUBTRACT_FROM_HALFWORD        = 6'b0001_10,
        SUBTRACT_FROM_HALFWORD_IMMEDIATE = 6'b0001_11,
        CARRY_GENERATE                = 6'b0010_00,
        BORROW_GENERATE               = 6'b0011_00,
        AND_REGISTER                  = 6'b0100_00,
        AND_WORD_IMMEDIATE            = 6'b0100_01,
        AND_HALFWORD_IMMEDIATE        = 6'b0100_11,
        AND_WITH_COMPLEMENT           = 6'b0101_00,
        OR_REGISTER                   = 6'b0110_00,
        OR_WORD_IMMEDIATE             = 6'b0110_01,
        OR_HALFWORD_IMMEDIATE         = 6'b0110_11,
        OR_WITH_COMPLEMENT            = 6'b0111_00,
        EXCLUSIVE_OR                  = 6'b1000_00,
        EXCLUSIVE_OR_WORD_IMMEDIATE   = 6'b1000_01,
        EXCLUSIVE_OR_HALFWORD_IMMEDIATE = 6'b1000_11,
        NAND_REGISTER                 = 6'b1001_00,
        NOR_REGISTER                  = 6'b1010_00,
        COMPARE_EQUAL_WORD            = 6'b1011_00,
        COMPARE_EQUAL_WORD_IMMEDIATE  = 6'b1011_01,
        COMPARE_EQUAL_HALFWORD        = 6'b1011_10,
        COMPARE_EQUAL_HALFWORD_IMMEDIATE = 6'b1011_11,
        COMPARE_GREATER_THAN_WORD     = 6'b1100_00,
        COMPARE_GREATER_THAN_WORD_IMMEDIATE = 6'b1100_01,
        COMPARE_GREATER_THAN_HALFWORD = 6'b1100_10,
        COMPARE_GREATER_THAN_HALFWORD_IMMEDIATE = 6'b1100_11,
        COMPARE_LOGICAL_GREATER_THAN_WORD = 6'b1101_00,
        COMPARE_LOGICAL_GREATER_THAN_WORD_IMMEDIATE = 6'b1101_01,
        COMPARE_LOGICAL_GREATER_THAN_HALFWORD = 6'b1101_10,
        COMPARE_LOGICAL_GREATER_THAN_HALFWORD_IMMEDIATE = 6'b1101_11,
        SHIFT_LEFT_WORD               = 6'b1110_00,
        SHIFT_LEFT_WORD_IMMEDIATE     = 6'b1110_01,
        SHIFT_LEFT_HALFWORD           = 6'b1110_10,
        SHIFT_LEFT_HALFWORD_IMMEDIATE = 6'b1110_11,
        ROTATE_WORD                   = 6'b1111_00,
        ROTATE_WORD_IMMEDIATE         = 6'b1111_01,
        ROTATE_HALFWORD               = 6'b1111_10,
        ROTATE_HALFWORD_IMMEDIATE     = 6'b1111_11
    } opcode_e;

    typedef enum logic [1:0] {
        SIMPLE_FIXED_1 = 2'd0,  // add, logic and compare
        SIMPLE_FIXED_2 = 2'd1,  // shift and rotate
        NO_UNIT        = 2'd3
    } unit_id_e;

    typedef enum logic [3:0] {
        ADD, SUB_FROM, CARRY, BORROW, AND, ANDC, OR, ORC, XOR, NAND, NOR, CEQ, CGT, CLGT
    } fx_op_e;

    typedef enum logic [1:0] {
        SHL,
        ROT
    } sr_op_e;

    typedef struct packed {
        logic                    valid;
        unit_id_e                unit_id;
        fx_op_e                  fx_op;
        sr_op_e                  sr_op;
        logic                    halfword;  // eight lanes instead of four
        spu_data_pkg::reg_addr_t rt_addr;
    } even_ctrl_t;

endpackage

`default_nettype wire

// File: include/even_pipe_tests.svh
`ifndef EVEN_PIPE_TESTS_SVH
`define EVEN_PIPE_TESTS_SVH

    task automatic test_reset();
        int err_start;
        err_start = errors;
        repeat (16) begin
            @(posedge clk);
            #DRIVE_SKEW;
            check_en("wb.reg_wr_en", 1'b0, wb.reg_wr_en);
        end
        arst_n = 1'b1;
        repeat (4) begin  // nothing issued yet
            @(posedge clk);
            #DRIVE_SKEW;
            check_en("wb.reg_wr_en", 1'b0, wb.reg_wr_en);
        end
        report_test("reset", err_start);
    endtask

    // every kept opcode on random operands
    task automatic test_arith_logic();
        spu_isa_pkg::opcode_e op;
        int                   err_start;
        err_start = errors;
        repeat (3) begin
            op = op.first();
            do begin
                issue_op(op, rand_bits(128), rand_bits(128), 10'(rand_bits(10)),
                         7'(rand_bits(7)), 7'(rand_bits(7)));
                op = op.next();
            end while (op != op.first());
        end
        drain();
        report_test("arith_logic", err_start);
    endtask

    task automatic test_compare_edges();
        spu_data_pkg::quadword_u q;
        int                      err_start;
        err_start = errors;
        q = rand_bits(128);
        issue_op(spu_isa_pkg::COMPARE_EQUAL_WORD, q, q, 10'd0, 7'd0, 7'd1);
        issue_op(spu_isa_pkg::COMPARE_EQUAL_HALFWORD, q, q ^ {16'h0001, 112'd0}, 10'd0, 7'd0, 7'd2);
        issue_op(spu_isa_pkg::COMPARE_GREATER_THAN_HALFWORD, {8{16'h8000}}, {8{16'h0001}},
                 10'd0, 7'd0, 7'd3);
        issue_op(spu_isa_pkg::COMPARE_LOGICAL_GREATER_THAN_HALFWORD, {8{16'h8000}},
                 {8{16'h0001}}, 10'd0, 7'd0, 7'd4);
        issue_op(spu_isa_pkg::COMPARE_GREATER_THAN_WORD, {4{32'h80000000}}, {4{32'h1}},
                 10'd0, 7'd0, 7'd5);
        issue_op(spu_isa_pkg::COMPARE_LOGICAL_GREATER_THAN_WORD, {4{32'h80000000}},
                 {4{32'h1}}, 10'd0, 7'd0, 7'd6);
        issue_op(spu_isa_pkg::COMPARE_GREATER_THAN_HALFWORD_IMMEDIATE, '0, '0,
                 10'h200, 7'd0, 7'd7);  // zero against -512
        issue_op(spu_isa_pkg::COMPARE_LOGICAL_GREATER_THAN_HALFWORD_IMMEDIATE, '0, '0,
                 10'h200, 7'd0, 7'd8);
        issue_op(spu_isa_pkg::COMPARE_EQUAL_WORD_IMMEDIATE, {4{32'hfffffe00}}, '0,
                 10'h200, 7'd0, 7'd9);
        issue_op(spu_isa_pkg::CARRY_GENERATE,
                 {32'hffffffff, 32'hfffffffe, 32'h0, 32'h80000000},
                 {32'h1, 32'h1, 32'h0, 32'h80000000}, 10'd0, 7'd0, 7'd10);
        issue_op(spu_isa_pkg::BORROW_GENERATE,
                 {32'h5, 32'h6, 32'h0, 32'hffffffff},
                 {32'h5, 32'h5, 32'h0, 32'h0}, 10'd0, 7'd0, 7'd11);
        issue_op(spu_isa_pkg::SUBTRACT_FROM_HALFWORD, {8{16'h0001}}, '0, 10'd0, 7'd0, 7'd12);
        drain();
        report_test("compare_edges", err_start);
    endtask

    task automatic test_shift_rotate();
        int                   counts[8] = '{0, 1, 15, 16, 31, 32, 63, 127};
        spu_isa_pkg::opcode_e ops[8] = '{spu_isa_pkg::SHIFT_LEFT_WORD,
            spu_isa_pkg::SHIFT_LEFT_WORD_IMMEDIATE, spu_isa_pkg::SHIFT_LEFT_HALFWORD,
            spu_isa_pkg::SHIFT_LEFT_HALFWORD_IMMEDIATE, spu_isa_pkg::ROTATE_WORD,
            spu_isa_pkg::ROTATE_WORD_IMMEDIATE, spu_isa_pkg::ROTATE_HALFWORD,
            spu_isa_pkg::ROTATE_HALFWORD_IMMEDIATE};
        spu_data_pkg::quadword_u cnt_q;
        int                      err_start;
        err_start = errors;
        foreach (ops[i]) begin
            foreach (counts[j]) begin
                cnt_q = ops[i][1] ? {8{16'(counts[j])}} : {4{32'(counts[j])}};
                issue_op(ops[i], rand_bits(128), cnt_q, 10'd0, 7'(counts[j]), 7'(j));
            end
        end
        drain();
        report_test("shift_rotate", err_start);
    endtask

    // mixed units on consecutive cycles, with idle and unkept slots between
    task automatic test_back_to_back();
        spu_isa_pkg::opcode_e burst[8] = '{spu_isa_pkg::ADD_WORD,
            spu_isa_pkg::SHIFT_LEFT_HALFWORD, spu_isa_pkg::ROTATE_WORD_IMMEDIATE,
            spu_isa_pkg::COMPARE_GREATER_THAN_HALFWORD, spu_isa_pkg::OR_WORD_IMMEDIATE,
            spu_isa_pkg::ROTATE_HALFWORD, spu_isa_pkg::SUBTRACT_FROM_WORD_IMMEDIATE,
            spu_isa_pkg::NOR_REGISTER};
        int err_start;
        err_start = errors;
        foreach (burst[i])
            issue_op(burst[i], rand_bits(128), rand_bits(128), 10'(rand_bits(10)),
                     7'(rand_bits(7)), 7'(i + 32));
        repeat (3) idle_slot();
        issue_unkept(6'b0010_10);  // halfword carry
        issue_op(spu_isa_pkg::ADD_HALFWORD, rand_bits(128), rand_bits(128), 10'd0, 7'd0, 7'd50);
        idle_slot();
        issue_unkept(6'b0100_10);
        issue_op(spu_isa_pkg::EXCLUSIVE_OR, rand_bits(128), rand_bits(128), 10'd0, 7'd0, 7'd51);
        drain();
        report_test("back_to_back", err_start);
    endtask

`endif

// File: verif/even_pipe_tb.sv
`default_nettype none
`timescale 1ns/100ps

module even_pipe_tb;

    localparam int NUM_TESTS  = 5;
    localparam int CYCLE_NS   = 100;
    localparam int DRIVE_SKEW = 10;
    localparam int PIPE_DEPTH = 3;  // drive cycle to visible writeback

    logic                              clk;
    logic                              arst_n;
    logic                              issue;
    spu_isa_pkg::opcode_e              opcode;
    spu_data_pkg::quadword_u           ra;
    spu_data_pkg::quadword_u           rb;
    logic [spu_data_pkg::IMM10_WIDTH-1:0] imm10;
    logic [spu_data_pkg::IMM7_WIDTH-1:0]  imm7;
    spu_data_pkg::reg_addr_t           rt_addr;
    spu_data_pkg::writeback_t          wb;

    int                                cycle;
    int                                checks;
    int                                errors;
    int                                tests_run;
    logic [31:0]                       lfsr;
    spu_data_pkg::writeback_t          wb_exp;
    spu_data_pkg::writeback_t          exp_q[$];  // expected packets in issue order
    int                                due_q[$];

    even_pipe even_pipe_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .opcode  (opcode),
        .ra      (ra),
        .rb      (rb),
        .imm10   (imm10),
        .imm7    (imm7),
        .rt_addr (rt_addr),
        .wb      (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CYCLE_NS / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        #(NUM_TESTS * 200 * CYCLE_NS);
        $display("watchdog expired at %0t, the tests did not finish in time", $time);
        $display("Errors found");
        $finish;
    end

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[126:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // a and b hold one lane of w bits, zero extended
    function automatic logic [31:0] lane_ref(input logic [3:0] f, input int w,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [63:0]        sum;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        int                 cnt;
        logic [31:0]        r;
        sum = {32'd0, a} + {32'd0, b};
        sa  = (w == 16) ? {{16{a[15]}}, a[15:0]} : a;
        sb  = (w == 16) ? {{16{b[15]}}, b[15:0]} : b;
        case (f)
            spu_isa_pkg::ADD:      r = a + b;
            spu_isa_pkg::SUB_FROM: r = b - a;
            spu_isa_pkg::CARRY:    r = {31'd0, sum[32]};
            spu_isa_pkg::BORROW:   r = {31'd0, b >= a};
            spu_isa_pkg::AND:      r = a & b;
            spu_isa_pkg::ANDC:     r = a & ~b;
            spu_isa_pkg::OR:       r = a | b;
            spu_isa_pkg::ORC:      r = a | ~b;
            spu_isa_pkg::XOR:      r = a ^ b;
            spu_isa_pkg::NAND:     r = ~(a & b);
            spu_isa_pkg::NOR:      r = ~(a | b);
            spu_isa_pkg::CEQ:      r = {31'd0, a == b};
            spu_isa_pkg::CGT:      r = {31'd0, sa > sb};
            spu_isa_pkg::CLGT:     r = {31'd0, a > b};
            4'd14: begin  // shift left, oversized counts clear the lane
                cnt = (w == 16) ? b[4:0] : b[5:0];
                r   = (cnt >= w) ? 32'd0 : a << cnt;
            end
            default: begin  // rotate left
                cnt = b % w;
                r   = (a << cnt) | (a >> (w - cnt));
            end
        endcase
        return r;
    endfunction

    // opcode fields are {operation, halfword, immediate}
    function automatic spu_data_pkg::quadword_u model(input spu_isa_pkg::opcode_e op,
        input spu_data_pkg::quadword_u a_q, input spu_data_pkg::quadword_u b_q,
        input logic [9:0] i10, input logic [6:0] i7);
        logic [127:0] va;
        logic [127:0] vb;
        logic [127:0] vr;
        logic [31:0]  mask;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  imm;
        int           w;
        int           pos;
        w    = op[1] ? 16 : 32;
        mask = op[1] ? 32'h0000ffff : 32'hffffffff;
        imm  = (op[5:2] >= 4'd14) ? {26'd0, i7[5:0]} : {{22{i10[9]}}, i10};
        va   = a_q;
        vb   = b_q;
        vr   = '0;
        for (int i = 0; i < 128 / w; i++) begin
            pos = 128 - (i + 1) * w;  // lane 0 is the top lane
            a   = (va >> pos) & mask;
            b   = op[0] ? (imm & mask) : ((vb >> pos) & mask);
            vr  = vr | ({96'd0, lane_ref(op[5:2], w, a, b) & mask} << pos);
        end
        return vr;
    endfunction

    // shift and rotate run in the second unit, everything else in the first
    function automatic spu_isa_pkg::unit_id_e unit_of(input spu_isa_pkg::opcode_e op);
        case (op)
            spu_isa_pkg::SHIFT_LEFT_WORD, spu_isa_pkg::SHIFT_LEFT_WORD_IMMEDIATE,
            spu_isa_pkg::SHIFT_LEFT_HALFWORD, spu_isa_pkg::SHIFT_LEFT_HALFWORD_IMMEDIATE,
            spu_isa_pkg::ROTATE_WORD, spu_isa_pkg::ROTATE_WORD_IMMEDIATE,
            spu_isa_pkg::ROTATE_HALFWORD, spu_isa_pkg::ROTATE_HALFWORD_IMMEDIATE:
                return spu_isa_pkg::SIMPLE_FIXED_2;
            default:
                return spu_isa_pkg::SIMPLE_FIXED_1;
        endcase
    endfunction

    task automatic check_quad(input string name, input spu_data_pkg::quadword_u exp,
                              input spu_data_pkg::quadword_u act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input spu_data_pkg::reg_addr_t exp,
                              input spu_data_pkg::reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_unit(input string name, input spu_isa_pkg::unit_id_e exp,
                              input spu_isa_pkg::unit_id_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_en(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // wb is compared mid cycle, well away from the edge
    always @(negedge clk) begin
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            wb_exp = exp_q.pop_front();
            void'(due_q.pop_front());
            check_en("wb.reg_wr_en", wb_exp.reg_wr_en, wb.reg_wr_en);
            if (wb_exp.reg_wr_en) begin
                check_unit("wb.unit_id", spu_isa_pkg::unit_id_e'(wb_exp.unit_id),
                           spu_isa_pkg::unit_id_e'(wb.unit_id));
                check_addr("wb.rt_addr", wb_exp.rt_addr, wb.rt_addr);
                check_quad("wb.rt_data", wb_exp.rt_data, wb.rt_data);
            end
        end
    end

    task automatic expect_slot(input spu_data_pkg::writeback_t e);
        exp_q.push_back(e);
        due_q.push_back(cycle + PIPE_DEPTH);
    endtask

    task automatic issue_op(input spu_isa_pkg::opcode_e op, input spu_data_pkg::quadword_u qa,
        input spu_data_pkg::quadword_u qb, input logic [9:0] i10, input logic [6:0] i7,
        input spu_data_pkg::reg_addr_t addr);
        spu_data_pkg::writeback_t e;
        @(posedge clk);
        #DRIVE_SKEW;
        issue   = 1'b1;
        opcode  = op;
        ra      = qa;
        rb      = qb;
        imm10   = i10;
        imm7    = i7;
        rt_addr = addr;
        e           = '0;
        e.reg_wr_en = 1'b1;
        e.unit_id   = unit_of(op);
        e.rt_addr   = addr;
        e.rt_data   = model(op, qa, qb, i10, i7);
        expect_slot(e);
    endtask

    task automatic issue_unkept(input logic [5:0] code);
        @(posedge clk);
        #DRIVE_SKEW;
        issue  = 1'b1;
        opcode = spu_isa_pkg::opcode_e'(code);
        expect_slot('0);
    endtask

    task automatic idle_slot();
        @(posedge clk);
        #DRIVE_SKEW;
        issue = 1'b0;
        expect_slot('0);
    endtask

    task automatic drain();
        @(posedge clk);
        #DRIVE_SKEW;
        issue = 1'b0;
        while (due_q.size() > 0)
            @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        $display("test %-14s finished with %0d mismatches", name, errors - err_start);
    endtask

`include "even_pipe_tests.svh"

    initial begin
        arst_n  = 1'b0;
        issue   = 1'b0;
        opcode  = spu_isa_pkg::ADD_WORD;
        ra      = '0;
        rb      = '0;
        imm10   = '0;
        imm7    = '0;
        rt_addr = '0;
        lfsr    = 32'd92933;
        test_reset();
        test_arith_logic();
        test_compare_edges();
        test_shift_rotate();
        test_back_to_back();
        $display("%0d tests, %0d checks, %0d mismatches", tests_run, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hdl/spu_data_pkg.sv
hdl/spu_isa_pkg.sv
hdl/even_decode.sv
hdl/even_simple_fixed.sv
hdl/even_shift_rotate.sv
hdl/even_result.sv
hdl/even_pipe.sv
verif/even_pipe_tb.sv
